/* Makefile */
TOP = brPredFetchTb

.PHONY: help test clean

help:
	@echo "test  - build and run the testbench with Verilator"
	@echo "clean - remove the Verilator build directory"

test:
	verilator --binary --assert --timing --top-module $(TOP) -f brPredFetch.f -o $(TOP)
	@out=$$(./obj_dir/$(TOP)); echo "$$out"; echo "$$out" | grep -qF "** PASS **"

clean:
	rm -rf obj_dir

/* bench/brRefModel.svh */
// Reference model of the predictor tables, included inside the testbench module
// Sized for 32 buffer entries and 5 history bits, matching the testbench parameters
`ifndef BR_REF_MODEL_SVH
`define BR_REF_MODEL_SVH

logic        refBtbValid  [32];
logic        refBtbJump   [32];
logic [24:0] refBtbTag    [32];
logic [31:0] refBtbTarget [32];
logic [1:0]  refPht       [32];
logic [4:0]  refGhr;

task automatic modelReset();
    for (int i = 0; i < 32; i++) begin
        refBtbValid[i] = 1'b0;
        refPht[i]      = 2'd1;
    end
    refGhr = '0;
endtask

function automatic logic [4:0] modelIdx(input logic [31:0] pc);
    return pc[6:2] ^ refGhr;
endfunction

function automatic logic modelPredict(input logic [31:0] pc);
    logic hit;
    hit = refBtbValid[pc[6:2]] && (refBtbTag[pc[6:2]] == pc[31:7]);
    return hit && (refBtbJump[pc[6:2]] || refPht[modelIdx(pc)] >= 2'd2);
endfunction

// Taken outcomes fill the buffer, conditional ones train a counter and the history
task automatic modelResolve(input logic isJal, input logic taken, input logic [31:0] pc,
                            input logic [31:0] target, input logic [4:0] phtIdx);
    if (taken) begin
        refBtbValid[pc[6:2]]  = 1'b1;
        refBtbJump[pc[6:2]]   = isJal;
        refBtbTag[pc[6:2]]    = pc[31:7];
        refBtbTarget[pc[6:2]] = target;
    end
    if (!isJal) begin
        if (taken && refPht[phtIdx] != 2'd3) refPht[phtIdx] = refPht[phtIdx] + 2'd1;
        if (!taken && refPht[phtIdx] != 2'd0) refPht[phtIdx] = refPht[phtIdx] - 2'd1;
        refGhr = {refGhr[3:0], taken};
    end
endtask

// B-type with x0 operands, J-type writing x1
function automatic logic [31:0] encBranch(input logic [2:0] funct3, input logic [12:0] imm);
    return {imm[12], imm[10:5], 5'd0, 5'd0, funct3, imm[4:1], imm[11], 7'b1100011};
endfunction

function automatic logic [31:0] encJal(input logic [20:0] imm);
    return {imm[20], imm[10:1], imm[11], imm[19:12], 5'd1, 7'b1101111};
endfunction

`endif

/* bench/brPredFetchTb.sv */
// Testbench for the fetch-address generator with branch prediction
// Concurrent assertions compare the DUT with an included table model
// The model assumes 32 buffer entries and 5 history bits
`timescale 1ns/1ps

module brPredFetchTb;

    localparam int cycleLimit = 2000;

    typedef struct packed {
        logic        valid;
        logic        isJal;
        logic        taken;
        logic        predTaken;
        logic [4:0]  phtIdx;
        logic [31:0] pc;
        logic [31:0] target;
    } pendT;

    logic            clk = 1'b0;
    logic            reset;
    brPkg::resolveT  resolve_i;
    logic            fetchReady_i;
    brPkg::fetchReqT fetch_o;
    logic            fetchValid_o;
    brPkg::redirectT redirect_o;

    int          errors = 0;
    int          records = 0;
    int          cycles = 0;
    logic        readyHigh = 1'b0;
    pendT        pend;
    pendT        stage1;
    logic        expRedValid;
    logic [31:0] expRedPc;
    logic        held;
    logic [31:0] heldTarget;
    logic        expPred;
    logic [4:0]  expIdx;
    logic [31:0] itemTarget;

    `include "brRefModel.svh"

    brPredFetch #(.btbEntries(32), .ghrBits(5), .pcStart(32'h0)) brPredFetch_inst (
        .clk          (clk),
        .reset        (reset),
        .resolve_i    (resolve_i),
        .fetchReady_i (fetchReady_i),
        .fetch_o      (fetch_o),
        .fetchValid_o (fetchValid_o),
        .redirect_o   (redirect_o)
    );

    always #10 clk = ~clk;

    // Model tables are written one edge after the DUT registers a record
    always @(posedge clk) begin
        if (reset) begin
            modelReset();
            stage1 = '0;
        end else begin
            if (stage1.valid) begin
                modelResolve(stage1.isJal, stage1.taken, stage1.pc, stage1.target,
                             stage1.phtIdx);
            end
            stage1 = pend;
        end
        expRedValid = stage1.valid && (stage1.taken != stage1.predTaken);
        expRedPc    = stage1.taken ? stage1.target : stage1.pc + 32'd4;
        held       <= !reset && fetchValid_o && !fetchReady_i && !redirect_o.valid;
        heldTarget <= itemTarget;
    end

    always_comb begin
        expIdx     = fetch_o.pc[6:2] ^ refGhr;
        expPred    = refBtbValid[fetch_o.pc[6:2]] && refBtbTag[fetch_o.pc[6:2]] == fetch_o.pc[31:7]
                     && (refBtbJump[fetch_o.pc[6:2]] || refPht[expIdx][1]);
        itemTarget = held ? heldTarget : refBtbTarget[fetch_o.pc[6:2]];
    end

    always @(posedge clk) begin
        #1;
        fetchReady_i <= readyHigh ? 1'b1 : 1'($urandom % 2);
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= cycleLimit) begin
            $display("timeout: the run did not finish within %0d cycles, %0d errors",
                     cycleLimit, errors);
            $display("** FAIL **");
            $finish;
        end
    end

    task automatic reportError(input string msg);
        errors++;
        $display("error at %0t: %s", $time, msg);
    endtask

    aValid: assert property (@(posedge clk) disable iff (reset)
        fetchValid_o == !$past(reset))
        else reportError("fetch valid does not follow reset");
    aFirst: assert property (@(posedge clk) disable iff (reset)
        $rose(fetchValid_o) |-> fetch_o.pc == 32'h0 && !fetch_o.predTaken && !redirect_o.valid)
        else reportError("first fetch item is wrong");
    aStable: assert property (@(posedge clk) disable iff (reset)
        fetchValid_o && !fetchReady_i && !redirect_o.valid |=> $stable(fetch_o))
        else reportError("stalled item changed");
    aPred: assert property (@(posedge clk) disable iff (reset)
        fetchValid_o && !held |-> fetch_o.predTaken == expPred && fetch_o.phtIdx == 8'(expIdx))
        else reportError("prediction differs from model");
    aNext: assert property (@(posedge clk) disable iff (reset)
        fetchValid_o && fetchReady_i && !redirect_o.valid |=> fetch_o.pc ==
        ($past(fetch_o.predTaken) ? $past(itemTarget) : $past(fetch_o.pc) + 32'd4))
        else reportError("wrong next fetch pc");
    aRedirect: assert property (@(posedge clk) disable iff (reset)
        redirect_o.valid == expRedValid && (!expRedValid || redirect_o.pc == expRedPc))
        else reportError("wrong redirect");
    aAfterRed: assert property (@(posedge clk) disable iff (reset)
        redirect_o.valid |=> fetch_o.pc == $past(redirect_o.pc))
        else reportError("redirect not followed");

    // Record holds for one cycle, then the pipeline drains
    task automatic issueRecord(input pendT p, input logic [31:0] instr,
                               input logic [31:0] a, input logic [31:0] b);
        @(posedge clk);
        #1;
        p.predTaken = modelPredict(p.pc);
        p.phtIdx    = modelIdx(p.pc);
        resolve_i   = '{valid: 1'b1, pc: p.pc, instr: instr, rs1Val: a, rs2Val: b,
                        predTaken: p.predTaken, phtIdx: 8'(p.phtIdx)};
        pend        = p;
        records++;
        @(posedge clk);
        #1;
        resolve_i.valid = 1'b0;
        pend.valid      = 1'b0;
        repeat (3) @(posedge clk);
    endtask

    task automatic sendBranch(input logic isBne, input logic [31:0] pc, input logic [12:0] imm,
                              input logic [31:0] a, input logic [31:0] b);
        pendT p;
        p        = '0;
        p.valid  = 1'b1;
        p.pc     = pc;
        p.taken  = isBne ? (a != b) : (a == b);
        p.target = pc + {{19{imm[12]}}, imm};
        issueRecord(p, encBranch(isBne ? 3'b001 : 3'b000, imm), a, b);
    endtask

    task automatic sendJal(input logic [31:0] pc, input logic [20:0] imm);
        pendT p;
        p        = '0;
        p.valid  = 1'b1;
        p.isJal  = 1'b1;
        p.pc     = pc;
        p.taken  = 1'b1;
        p.target = pc + {{11{imm[20]}}, imm};
        issueRecord(p, encJal(imm), 32'd0, 32'd0);
    endtask

    initial begin
        void'($urandom(83));
        reset        = 1'b1;
        fetchReady_i = 1'b0;
        resolve_i    = '0;
        pend         = '0;
        repeat (5) @(posedge clk);
        #1;
        reset = 1'b0;
        repeat (30) @(posedge clk);
        // Untrained beq and bne, both outcomes each
        sendBranch(1'b0, 32'h100, 13'h040, 32'd7, 32'd7);
        sendBranch(1'b0, 32'h110, 13'h040, 32'd7, 32'd8);
        sendBranch(1'b1, 32'h120, 13'h1f80, 32'd1, 32'd2);
        sendBranch(1'b1, 32'h130, 13'h020, 32'd5, 32'd5);
        // Saturate history and the counter for one branch
        for (int i = 0; i < 10; i++) begin
            sendBranch(1'b0, 32'h200, 13'h080, 32'd3, 32'd3);
        end
        // Jal in another buffer slot leads fetch back to the trained branch
        sendJal(32'h510, -21'd784);
        repeat (20) @(posedge clk);
        // Jal fills the buffer, a second jal leads fetch back to it
        sendJal(32'h304, 21'h100);
        sendJal(32'h608, -21'd772);
        repeat (20) @(posedge clk);
        // Trained branch now resolves not taken
        sendBranch(1'b0, 32'h200, 13'h080, 32'd3, 32'd4);
        readyHigh = 1'b1;
        repeat (20) @(posedge clk);
        $display("closing: %0d records resolved, %0d errors", records, errors);
        if (errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

/* brPredFetch.f */
+incdir+bench
hdl/brPkg.sv
hdl/resolveDecode.sv
hdl/predTables.sv
hdl/fetchAddrGen.sv
hdl/brPredFetch.sv
bench/brPredFetchTb.sv

/* hdl/brPkg.sv */
// Shared types for the fetch-address generator and branch predictor
// phtIdx fields are fixed at 8 bits, and only the low ghrBits are meaningful
// Only beq, bne and jal are decoded by this design
package brPkg;

    // Width of a PC and of operand data
    localparam int pcWidth = 32;

    // RV32I opcodes
    localparam logic [6:0] opBranch = 7'b1100011;
    localparam logic [6:0] opJal    = 7'b1101111;

    // Branch funct3 codes
    localparam logic [2:0] funct3Beq = 3'b000;
    localparam logic [2:0] funct3Bne = 3'b001;

    // Item on the fetch stream
    typedef struct packed {
        logic [pcWidth-1:0] pc;
        logic               predTaken;
        logic [7:0]         phtIdx;
    } fetchReqT;

    // Resolved branch record, as returned by the execute side
    typedef struct packed {
        logic               valid;
        logic [pcWidth-1:0] pc;
        logic [31:0]        instr;
        logic [pcWidth-1:0] rs1Val;
        logic [pcWidth-1:0] rs2Val;
        // Prediction that fetch attached to this pc
        logic               predTaken;
        logic [7:0]         phtIdx;
    } resolveT;

    // Fetch redirect after a mispredict
    typedef struct packed {
        logic               valid;
        logic [pcWidth-1:0] pc;
    } redirectT;

    // Table update from a resolved record
    // isCond and isJump are already qualified by a valid record
    typedef struct packed {
        logic               isCond;
        logic               isJump;
        logic               taken;
        logic [pcWidth-1:0] pc;
        logic [pcWidth-1:0] target;
        logic [7:0]         phtIdx;
    } updateT;

endpackage

/* hdl/brPredFetch.sv */
// Top level of the fetch-address generator with branch prediction
// Resolve records are always accepted; only fetch has back-pressure
`timescale 1ns/1ps

module brPredFetch #(
    parameter int                        btbEntries = 32,
    parameter int                        ghrBits    = 5,
    parameter logic [brPkg::pcWidth-1:0] pcStart    = '0
) (
    input  logic            clk,
    input  logic            reset,
    input  brPkg::resolveT  resolve_i,
    input  logic            fetchReady_i,
    output brPkg::fetchReqT fetch_o,
    output logic            fetchValid_o,
    output brPkg::redirectT redirect_o
);

    brPkg::updateT             update;
    logic [brPkg::pcWidth-1:0] fetchPc;
    logic                      predTaken;
    logic [brPkg::pcWidth-1:0] predTarget;
    logic [7:0]                phtIdx;

    resolveDecode resolveDecode_inst (
        .clk        (clk),
        .reset      (reset),
        .resolve_i  (resolve_i),
        .update_o   (update),
        .redirect_o (redirect_o)
    );

    predTables #(
        .btbEntries (btbEntries),
        .ghrBits    (ghrBits)
    ) predTables_inst (
        .clk          (clk),
        .reset        (reset),
        .lookupPc_i   (fetchPc),
        .update_i     (update),
        .predTaken_o  (predTaken),
        .predTarget_o (predTarget),
        .phtIdx_o     (phtIdx)
    );

    fetchAddrGen #(
        .pcStart (pcStart)
    ) fetchAddrGen_inst (
        .clk          (clk),
        .reset        (reset),
        .predTaken_i  (predTaken),
        .predTarget_i (predTarget),
        .phtIdx_i     (phtIdx),
        .redirect_i   (redirect_o),
        .fetchReady_i (fetchReady_i),
        .fetchPc_o    (fetchPc),
        .fetch_o      (fetch_o),
        .fetchValid_o (fetchValid_o)
    );

endmodule

/* hdl/fetchAddrGen.sv */
// Fetch PC register with valid/ready handshake and redirect
// A stalled item is held, including its prediction, until it is taken
// A redirect always wins and supersedes any item transferred that cycle
`timescale 1ns/1ps

module fetchAddrGen #(
    parameter logic [brPkg::pcWidth-1:0] pcStart = '0
) (
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      predTaken_i,
    input  logic [brPkg::pcWidth-1:0] predTarget_i,
    input  logic [7:0]                phtIdx_i,
    input  brPkg::redirectT           redirect_i,
    input  logic                      fetchReady_i,
    output logic [brPkg::pcWidth-1:0] fetchPc_o,
    output brPkg::fetchReqT           fetch_o,
    output logic                      fetchValid_o
);

    logic [brPkg::pcWidth-1:0] pcQ;
    logic                      validQ;
    logic                      stallQ;
    brPkg::fetchReqT           heldReqQ;
    logic [brPkg::pcWidth-1:0] heldTargetQ;
    logic [brPkg::pcWidth-1:0] target;
    logic                      xfer;
    logic [brPkg::pcWidth-1:0] pcNext;

    assign fetchPc_o    = pcQ;
    assign fetchValid_o = validQ;
    assign xfer         = validQ && fetchReady_i;

    // Tables may change under a stalled item, so freeze what was shown
    always_comb begin
        if (stallQ) begin
            fetch_o = heldReqQ;
            target  = heldTargetQ;
        end else begin
            fetch_o.pc        = pcQ;
            fetch_o.predTaken = predTaken_i;
            fetch_o.phtIdx    = phtIdx_i;
            target            = predTarget_i;
        end
    end

    always_comb begin
        if (redirect_i.valid) begin
            pcNext = redirect_i.pc;
        end else if (xfer) begin
            pcNext = fetch_o.predTaken ? target : pcQ + 32'd4;
        end else begin
            pcNext = pcQ;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            pcQ    <= pcStart;
            validQ <= 1'b0;
            stallQ <= 1'b0;
        end else begin
            pcQ    <= pcNext;
            validQ <= 1'b1;
            stallQ <= validQ && !fetchReady_i && !redirect_i.valid;
        end
    end

    always_ff @(posedge clk) begin
        heldReqQ    <= fetch_o;
        heldTargetQ <= target;
    end

    // The live pc must not move while a stalled item is held
    assert property (@(posedge clk) disable iff (reset)
        stallQ |-> (fetch_o.pc == pcQ));

endmodule

/* hdl/predTables.sv */
// Direct-mapped target buffer plus a gshare table of 2-bit counters
// btbEntries must be a power of two, ghrBits ranges from 1 to 8
// History shifts only when a conditional branch resolves
`timescale 1ns/1ps

module predTables #(
    parameter int btbEntries = 32,
    parameter int ghrBits    = 5
) (
    input  logic                      clk,
    input  logic                      reset,
    input  logic [brPkg::pcWidth-1:0] lookupPc_i,
    input  brPkg::updateT             update_i,
    output logic                      predTaken_o,
    output logic [brPkg::pcWidth-1:0] predTarget_o,
    output logic [7:0]                phtIdx_o
);

    localparam int idxBits    = $clog2(btbEntries);
    localparam int tagBits    = brPkg::pcWidth - idxBits - 2;
    localparam int phtEntries = 1 << ghrBits;

    typedef struct packed {
        logic                      jump;
        logic [tagBits-1:0]        tag;
        logic [brPkg::pcWidth-1:0] target;
    } btbEntryT;

    logic     btbValid [btbEntries];
    btbEntryT btbMem   [btbEntries];
    logic [1:0]         pht [phtEntries];
    logic [ghrBits-1:0] ghr;

    logic [idxBits-1:0] lookIdx;
    logic [tagBits-1:0] lookTag;
    logic               lookHit;
    logic [ghrBits-1:0] lookPht;
    logic [idxBits-1:0] updIdx;
    logic [ghrBits-1:0] updPht;
    logic               btbWrite;

    // Lookup
    assign lookIdx = lookupPc_i[idxBits+1:2];
    assign lookTag = lookupPc_i[brPkg::pcWidth-1:idxBits+2];
    assign lookHit = btbValid[lookIdx] && (btbMem[lookIdx].tag == lookTag);
    // Gshare hash of word address and history
    assign lookPht = lookupPc_i[ghrBits+1:2] ^ ghr;

    assign predTaken_o  = lookHit && (btbMem[lookIdx].jump || pht[lookPht][1]);
    assign predTarget_o = btbMem[lookIdx].target;
    assign phtIdx_o     = 8'(lookPht);

    // Update
    assign updIdx   = update_i.pc[idxBits+1:2];
    assign updPht   = update_i.phtIdx[ghrBits-1:0];
    assign btbWrite = (update_i.isCond || update_i.isJump) && update_i.taken;

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < btbEntries; i++) begin
                btbValid[i] <= 1'b0;
            end
        end else if (btbWrite) begin
            btbValid[updIdx] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (btbWrite) begin
            btbMem[updIdx].jump   <= update_i.isJump;
            btbMem[updIdx].tag    <= update_i.pc[brPkg::pcWidth-1:idxBits+2];
            btbMem[updIdx].target <= update_i.target;
        end
    end

    // Counters start weakly not-taken
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < phtEntries; i++) begin
                pht[i] <= 2'd1;
            end
            ghr <= '0;
        end else if (update_i.isCond) begin
            if (update_i.taken && pht[updPht] != 2'd3) begin
                pht[updPht] <= pht[updPht] + 2'd1;
            end else if (!update_i.taken && pht[updPht] != 2'd0) begin
                pht[updPht] <= pht[updPht] - 2'd1;
            end
            // Outcome enters at bit 0
            ghr <= ghrBits'({ghr, update_i.taken});
        end
    end

    // A taken update makes its pc hit in the buffer from the next edge
    assert property (@(posedge clk) disable iff (reset)
        btbWrite |=> btbValid[$past(updIdx)]
            && btbMem[$past(updIdx)].tag == $past(update_i.pc[brPkg::pcWidth-1:idxBits+2]));

endmodule

/* hdl/resolveDecode.sv */
// Registers one resolved record per cycle and decodes beq, bne and jal
// Any other encoding is ignored and produces no update and no redirect
`timescale 1ns/1ps

module resolveDecode (
    input  logic            clk,
    input  logic            reset,
    input  brPkg::resolveT  resolve_i,
    output brPkg::updateT   update_o,
    output brPkg::redirectT redirect_o
);

    brPkg::resolveT resolveQ;

    logic [6:0]                opcode;
    logic [2:0]                funct3;
    logic                      isBeq;
    logic                      isBne;
    logic                      isJal;
    logic                      operandsEq;
    logic                      taken;
    logic [brPkg::pcWidth-1:0] bImm;
    logic [brPkg::pcWidth-1:0] jImm;
    logic [brPkg::pcWidth-1:0] target;
    logic [brPkg::pcWidth-1:0] pcPlus4;

    // Payload follows the input every cycle, only valid is cleared
    always_ff @(posedge clk) begin
        resolveQ <= resolve_i;
        if (reset) begin
            resolveQ.valid <= 1'b0;
        end
    end

    assign opcode = resolveQ.instr[6:0];
    assign funct3 = resolveQ.instr[14:12];

    assign isBeq = resolveQ.valid && (opcode == brPkg::opBranch) && (funct3 == brPkg::funct3Beq);
    assign isBne = resolveQ.valid && (opcode == brPkg::opBranch) && (funct3 == brPkg::funct3Bne);
    assign isJal = resolveQ.valid && (opcode == brPkg::opJal);

    // B and J immediates, both sign extended with bit 0 clear
    assign bImm = {{20{resolveQ.instr[31]}}, resolveQ.instr[7], resolveQ.instr[30:25],
                   resolveQ.instr[11:8], 1'b0};
    assign jImm = {{12{resolveQ.instr[31]}}, resolveQ.instr[19:12], resolveQ.instr[20],
                   resolveQ.instr[30:21], 1'b0};

    assign operandsEq = (resolveQ.rs1Val == resolveQ.rs2Val);
    assign taken      = isJal || (isBeq && operandsEq) || (isBne && !operandsEq);
    assign target     = resolveQ.pc + (isJal ? jImm : bImm);
    assign pcPlus4    = resolveQ.pc + 32'd4;

    always_comb begin
        update_o.isCond = isBeq || isBne;
        update_o.isJump = isJal;
        update_o.taken  = taken;
        update_o.pc     = resolveQ.pc;
        update_o.target = target;
        update_o.phtIdx = resolveQ.phtIdx;
    end

    // Redirect only when the outcome disagrees with what fetch assumed
    always_comb begin
        redirect_o.valid = (isBeq || isBne || isJal) && (taken != resolveQ.predTaken);
        redirect_o.pc    = taken ? target : pcPlus4;
    end

    // The producer only returns records for control-flow instructions
    assert property (@(posedge clk) disable iff (reset)
        resolveQ.valid |-> (isBeq || isBne || isJal));

endmodule
